// File: common/isaPkg.sv
package isaPkg;

    // data and address width
    localparam int wordWidth = 16;

    // register file size and select width
    localparam int numRegs = 4;
    localparam int regAddrWidth = $clog2(numRegs);

    // field widths inside the instruction word
    localparam int immWidth = 8;
    localparam int targetWidth = 12;

    // JAL and JRL write their return address here
    localparam logic [regAddrWidth-1:0] linkReg = 2'd2;

    typedef enum logic [3:0] {
        BNE   = 4'd0,
        BEQ   = 4'd1,
        BGZ   = 4'd2,
        BLZ   = 4'd3,
        ADI   = 4'd4,
        ORI   = 4'd5,
        LHI   = 4'd6,
        LWD   = 4'd7,
        SWD   = 4'd8,
        JMP   = 4'd9,
        JAL   = 4'd10,
        RTYPE = 4'd15
    } opcode_t;

    // function field of RTYPE words
    typedef enum logic [5:0] {
        ADD = 6'd0,
        SUB = 6'd1,
        AND = 6'd2,
        ORR = 6'd3,
        NOT = 6'd4,
        TCP = 6'd5,
        SHL = 6'd6,
        SHR = 6'd7,
        JPR = 6'd25,
        JRL = 6'd26,
        WWD = 6'd28,
        HLT = 6'd29
    } func_t;

    typedef struct packed {
        opcode_t                 opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        func_t                   func;
    } rFormat_t;

    typedef struct packed {
        opcode_t                 opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [immWidth-1:0]     imm;
    } iFormat_t;

    typedef struct packed {
        opcode_t                opcode;
        logic [targetWidth-1:0] target;
    } jFormat_t;

    // one fetched word, three views; opcode sits in the same bits in all of them
    typedef union packed {
        rFormat_t r;
        iFormat_t i;
        jFormat_t j;
    } instrWord_t;

endpackage

// File: common/cpuPkg.sv
package cpuPkg;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluNot,
        aluTcp,
        aluShl,
        aluShr,
        aluPassB
    } aluOp_t;

    // which field names the destination register
    typedef enum logic [1:0] {
        dstRt,
        dstRd,
        dstLink
    } regDst_t;

    // source of the register write in WriteBack
    typedef enum logic [1:0] {
        wbAlu,
        wbMem,
        wbPcNext,
        wbImmHigh
    } wbSel_t;

    typedef struct packed {
        logic    branch;
        logic    jump;
        logic    jumpReg;
        logic    memRead;
        logic    memWrite;
        logic    regWrite;
        regDst_t regDst;
        wbSel_t  wbSel;
        aluOp_t  aluOp;
        logic    aluSrcImm;
        logic    outputEn;
        logic    halt;
    } ctrl_t;

    // no writes, no memory access
    localparam ctrl_t ctrlNop = '{
        regDst: dstRt,
        wbSel: wbAlu,
        aluOp: aluPassB,
        default: 1'b0
    };

    // request side of the memory strobe bus
    typedef struct packed {
        logic                         readM;
        logic                         writeM;
        logic [isaPkg::wordWidth-1:0] address;
        logic [isaPkg::wordWidth-1:0] writeData;
    } memReq_t;

endpackage

// File: datapath/alu.sv
`timescale 1ns/1ns

module alu (
    input  logic [isaPkg::wordWidth-1:0] a,
    input  logic [isaPkg::wordWidth-1:0] b,
    input  cpuPkg::aluOp_t               op,
    output logic [isaPkg::wordWidth-1:0] result,
    output logic                         overflow
);

    always_comb begin
        result = b;
        overflow = 1'b0;
        case (op)
            cpuPkg::aluAdd: begin
                result = a + b;
                // same-sign operands, result sign flipped
                overflow = (a[isaPkg::wordWidth-1] == b[isaPkg::wordWidth-1])
                    && (result[isaPkg::wordWidth-1] != a[isaPkg::wordWidth-1]);
            end
            cpuPkg::aluSub: begin
                result = a - b;
                overflow = (a[isaPkg::wordWidth-1] != b[isaPkg::wordWidth-1])
                    && (result[isaPkg::wordWidth-1] != a[isaPkg::wordWidth-1]);
            end
            cpuPkg::aluAnd: result = a & b;
            cpuPkg::aluOr: result = a | b;
            cpuPkg::aluNot: result = ~a;
            cpuPkg::aluTcp: result = ~a + 1'b1;
            cpuPkg::aluShl: result = {a[isaPkg::wordWidth-2:0], 1'b0};
            // arithmetic, sign bit is kept
            cpuPkg::aluShr: result = {a[isaPkg::wordWidth-1], a[isaPkg::wordWidth-1:1]};
            cpuPkg::aluPassB: result = b;
            default: result = b;
        endcase
    end

endmodule

// File: datapath/registerFile.sv
`timescale 1ns/1ns

module registerFile (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [isaPkg::regAddrWidth-1:0] readAddr1,
    input  logic [isaPkg::regAddrWidth-1:0] readAddr2,
    input  logic [isaPkg::regAddrWidth-1:0] writeAddr,
    input  logic [isaPkg::wordWidth-1:0]    writeData,
    input  logic                            writeEn,
    output logic [isaPkg::wordWidth-1:0]    readData1,
    output logic [isaPkg::wordWidth-1:0]    readData2
);

    logic [isaPkg::wordWidth-1:0] regs [isaPkg::numRegs];

    // writes land on the WriteBack edge
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < isaPkg::numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    // reads are combinational
    assign readData1 = regs[readAddr1];
    assign readData2 = regs[readAddr2];

endmodule

// File: datapath/datapath.sv
`timescale 1ns/1ns

module datapath (
    input  logic                         clk,
    input  logic                         rst,
    input  cpuPkg::ctrl_t                ctrl,
    output isaPkg::instrWord_t           instr,
    output cpuPkg::memReq_t              memReq,
    input  logic [isaPkg::wordWidth-1:0] readData,
    input  logic                         inputReady,
    input  logic                         ackOutput,
    output logic [isaPkg::wordWidth-1:0] outputValue,
    output logic                         outputValid,
    output logic                         halted
);

    typedef enum logic [2:0] {
        stFetch,
        stDecode,
        stExecute,
        stMemory,
        stWriteBack,
        stHalted
    } state_t;

    state_t state;

    logic [isaPkg::wordWidth-1:0] pc;
    logic [isaPkg::wordWidth-1:0] mdr;
    logic [isaPkg::wordWidth-1:0] regA;
    logic [isaPkg::wordWidth-1:0] regB;
    logic [isaPkg::wordWidth-1:0] aluOut;

    logic [isaPkg::wordWidth-1:0] rfData1;
    logic [isaPkg::wordWidth-1:0] rfData2;
    logic [isaPkg::wordWidth-1:0] immExt;
    logic [isaPkg::wordWidth-1:0] aluA;
    logic [isaPkg::wordWidth-1:0] aluB;
    logic [isaPkg::wordWidth-1:0] aluResult;
    logic [isaPkg::wordWidth-1:0] wbData;
    logic [isaPkg::wordWidth-1:0] nextPc;
    logic [isaPkg::regAddrWidth-1:0] wbAddr;
    logic branchTaken;
    logic rfWriteEn;

    // ORI zero extends, the rest sign extend
    assign immExt = (instr.i.opcode == isaPkg::ORI)
        ? {{(isaPkg::wordWidth-isaPkg::immWidth){1'b0}}, instr.i.imm}
        : {{(isaPkg::wordWidth-isaPkg::immWidth){instr.i.imm[isaPkg::immWidth-1]}}, instr.i.imm};

    // pc already points past this instruction during Execute
    assign aluA = ctrl.branch ? pc : regA;
    assign aluB = ctrl.aluSrcImm ? immExt : regB;
    assign rfWriteEn = (state == stWriteBack) && ctrl.regWrite;

    registerFile regs (
        .clk(clk),
        .rst(rst),
        .readAddr1(instr.r.rs),
        .readAddr2(instr.r.rt),
        .writeAddr(wbAddr),
        .writeData(wbData),
        .writeEn(rfWriteEn),
        .readData1(rfData1),
        .readData2(rfData2)
    );

    alu aluUnit (
        .a(aluA),
        .b(aluB),
        .op(ctrl.aluOp),
        .result(aluResult),
        .overflow()
    );

    always_comb begin
        case (instr.i.opcode)
            isaPkg::BNE: branchTaken = (regA != regB);
            isaPkg::BEQ: branchTaken = (regA == regB);
            isaPkg::BGZ: branchTaken = ($signed(regA) > 0);
            isaPkg::BLZ: branchTaken = ($signed(regA) < 0);
            default: branchTaken = 1'b0;
        endcase
    end

    // resolved in WriteBack so the link value is still pc plus one
    always_comb begin
        if (ctrl.jumpReg) begin
            nextPc = regA;
        end else if (ctrl.jump) begin
            nextPc = {pc[isaPkg::wordWidth-1:isaPkg::targetWidth], instr.j.target};
        end else if (ctrl.branch && branchTaken) begin
            nextPc = aluOut;
        end else begin
            nextPc = pc;
        end
    end

    always_comb begin
        case (ctrl.wbSel)
            cpuPkg::wbMem: wbData = mdr;
            cpuPkg::wbPcNext: wbData = pc;
            cpuPkg::wbImmHigh: wbData = {instr.i.imm, {(isaPkg::wordWidth-isaPkg::immWidth){1'b0}}};
            default: wbData = aluOut;
        endcase
        case (ctrl.regDst)
            cpuPkg::dstRd: wbAddr = instr.r.rd;
            cpuPkg::dstLink: wbAddr = isaPkg::linkReg;
            default: wbAddr = instr.r.rt;
        endcase
    end

    always_ff @(posedge clk) begin
        outputValid <= 1'b0;
        if (rst) begin
            state <= stFetch;
            pc <= '0;
            memReq.readM <= 1'b0;
            memReq.writeM <= 1'b0;
            halted <= 1'b0;
        end else begin
            case (state)
                stFetch: begin
                    if (memReq.readM && inputReady) begin
                        memReq.readM <= 1'b0;
                        instr <= readData;
                        pc <= pc + 1'b1;
                        state <= stDecode;
                    end else begin
                        // only the first fetch after reset raises the strobe here
                        memReq.readM <= 1'b1;
                        memReq.address <= pc;
                    end
                end
                stDecode: begin
                    regA <= rfData1;
                    regB <= rfData2;
                    state <= stExecute;
                end
                stExecute: begin
                    aluOut <= aluResult;
                    memReq.address <= aluResult;
                    memReq.writeData <= regB;
                    if (ctrl.memRead) begin
                        memReq.readM <= 1'b1;
                        state <= stMemory;
                    end else if (ctrl.memWrite) begin
                        memReq.writeM <= 1'b1;
                        state <= stMemory;
                    end else begin
                        state <= stWriteBack;
                    end
                end
                stMemory: begin
                    // wait here for as long as memory needs
                    if (memReq.readM && inputReady) begin
                        memReq.readM <= 1'b0;
                        mdr <= readData;
                        state <= stWriteBack;
                    end
                    if (memReq.writeM && ackOutput) begin
                        memReq.writeM <= 1'b0;
                        state <= stWriteBack;
                    end
                end
                stWriteBack: begin
                    pc <= nextPc;
                    if (ctrl.outputEn) begin
                        outputValid <= 1'b1;
                        outputValue <= regA;
                    end
                    if (ctrl.halt) begin
                        halted <= 1'b1;
                        state <= stHalted;
                    end else begin
                        // next fetch strobe goes out with the state change
                        memReq.readM <= 1'b1;
                        memReq.address <= nextPc;
                        state <= stFetch;
                    end
                end
                stHalted: state <= stHalted;
                default: state <= stFetch;
            endcase
        end
    end

endmodule

// File: source/controlUnit.sv
`timescale 1ns/1ns

module controlUnit (
    input  isaPkg::instrWord_t instr,
    output cpuPkg::ctrl_t      ctrl
);

    always_comb begin
        ctrl = cpuPkg::ctrlNop;
        case (instr.r.opcode)
            isaPkg::BNE, isaPkg::BEQ, isaPkg::BGZ, isaPkg::BLZ: begin
                // alu forms the target from pc and the immediate
                ctrl.branch = 1'b1;
                ctrl.aluOp = cpuPkg::aluAdd;
                ctrl.aluSrcImm = 1'b1;
            end
            isaPkg::ADI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp = cpuPkg::aluAdd;
                ctrl.aluSrcImm = 1'b1;
            end
            isaPkg::ORI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp = cpuPkg::aluOr;
                ctrl.aluSrcImm = 1'b1;
            end
            isaPkg::LHI: begin
                ctrl.regWrite = 1'b1;
                ctrl.wbSel = cpuPkg::wbImmHigh;
            end
            isaPkg::LWD: begin
                ctrl.memRead = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.wbSel = cpuPkg::wbMem;
                ctrl.aluOp = cpuPkg::aluAdd;
                ctrl.aluSrcImm = 1'b1;
            end
            isaPkg::SWD: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluOp = cpuPkg::aluAdd;
                ctrl.aluSrcImm = 1'b1;
            end
            isaPkg::JMP: ctrl.jump = 1'b1;
            isaPkg::JAL: begin
                ctrl.jump = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.regDst = cpuPkg::dstLink;
                ctrl.wbSel = cpuPkg::wbPcNext;
            end
            isaPkg::RTYPE: begin
                case (instr.r.func)
                    isaPkg::ADD: ctrl.aluOp = cpuPkg::aluAdd;
                    isaPkg::SUB: ctrl.aluOp = cpuPkg::aluSub;
                    isaPkg::AND: ctrl.aluOp = cpuPkg::aluAnd;
                    isaPkg::ORR: ctrl.aluOp = cpuPkg::aluOr;
                    isaPkg::NOT: ctrl.aluOp = cpuPkg::aluNot;
                    isaPkg::TCP: ctrl.aluOp = cpuPkg::aluTcp;
                    isaPkg::SHL: ctrl.aluOp = cpuPkg::aluShl;
                    isaPkg::SHR: ctrl.aluOp = cpuPkg::aluShr;
                    isaPkg::JPR: ctrl.jumpReg = 1'b1;
                    isaPkg::JRL: begin
                        ctrl.jumpReg = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst = cpuPkg::dstLink;
                        ctrl.wbSel = cpuPkg::wbPcNext;
                    end
                    isaPkg::WWD: ctrl.outputEn = 1'b1;
                    isaPkg::HLT: ctrl.halt = 1'b1;
                    default: ctrl = cpuPkg::ctrlNop;
                endcase
                // alu functions all write rd
                if (ctrl.aluOp != cpuPkg::aluPassB) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.regDst = cpuPkg::dstRd;
                end
            end
            default: ctrl = cpuPkg::ctrlNop;
        endcase
    end

endmodule

// File: source/cpuTop.sv
`timescale 1ns/1ns

module cpuTop (
    input  logic                         clk,
    input  logic                         rst,
    output cpuPkg::memReq_t              memReq,
    input  logic [isaPkg::wordWidth-1:0] readData,
    input  logic                         inputReady,
    input  logic                         ackOutput,
    output logic [isaPkg::wordWidth-1:0] outputValue,
    output logic                         outputValid,
    output logic                         halted
);

    // latched instruction and its decoded control bundle
    isaPkg::instrWord_t instr;
    cpuPkg::ctrl_t      ctrl;

    controlUnit decoder (
        .instr(instr),
        .ctrl(ctrl)
    );

    // multi-cycle core with the memory strobes
    datapath core (
        .clk(clk),
        .rst(rst),
        .ctrl(ctrl),
        .instr(instr),
        .memReq(memReq),
        .readData(readData),
        .inputReady(inputReady),
        .ackOutput(ackOutput),
        .outputValue(outputValue),
        .outputValid(outputValid),
        .halted(halted)
    );

endmodule

// File: tb/tbMemory.sv
`timescale 1ns/1ns

module tbMemory (
    input  logic                                clk,
    input  logic                                rst,
    input  cpuPkg::memReq_t                     req,
    output logic [isaPkg::wordWidth-1:0]        readData,
    output logic                                inputReady,
    output logic                                ackOutput,
    output logic                                writeSeen,
    output logic [isaPkg::wordWidth-1:0]        writeAddr,
    output logic [isaPkg::wordWidth-1:0]        writeValue
);

    // loaded by the testbench top before reset is released
    logic [isaPkg::wordWidth-1:0] words [256];

    integer seed = 39;
    logic busy;
    logic [1:0] waitCount;

    // bus is idle before the first clock edge
    initial begin
        readData = '0;
        inputReady = 1'b0;
        ackOutput = 1'b0;
    end

    always @(posedge clk) begin
        writeSeen <= 1'b0;
        if (rst) begin
            inputReady <= 1'b0;
            ackOutput <= 1'b0;
            readData <= '0;
            busy <= 1'b0;
            waitCount <= '0;
            writeAddr <= '0;
            writeValue <= '0;
        end else if (inputReady || ackOutput) begin
            // core takes the reply at this edge and drops its strobe
            inputReady <= 1'b0;
            ackOutput <= 1'b0;
            busy <= 1'b0;
        end else if (busy) begin
            if (waitCount == 0) begin
                if (req.readM) begin
                    readData <= words[req.address[7:0]];
                    inputReady <= 1'b1;
                end else if (req.writeM) begin
                    words[req.address[7:0]] <= req.writeData;
                    ackOutput <= 1'b1;
                    writeSeen <= 1'b1;
                    writeAddr <= req.address;
                    writeValue <= req.writeData;
                end else begin
                    busy <= 1'b0;
                end
            end else begin
                waitCount <= waitCount - 1'b1;
            end
        end else if (req.readM || req.writeM) begin
            // random extra latency of 0 to 3 cycles
            busy <= 1'b1;
            waitCount <= $unsigned($random(seed)) % 4;
        end
    end

endmodule

// File: tb/cpuTb.sv
`timescale 1ns/1ns

module cpuTb;

    localparam int resetCycles = 10;
    localparam int progLen = 62;

    logic clk;
    logic rst;
    cpuPkg::memReq_t memReq;
    logic [15:0] readData;
    logic inputReady;
    logic ackOutput;
    logic [15:0] outputValue;
    logic outputValid;
    logic halted;
    logic writeSeen;
    logic [15:0] writeAddr;
    logic [15:0] writeValue;

    logic [15:0] image [256];
    logic [15:0] refMem [256];
    logic [15:0] expOutputs [$];
    logic [15:0] expWriteAddr [$];
    logic [15:0] expWriteData [$];
    int cycleLimit;
    int cycles;
    int haltCycles;
    int refCount;

    cpuTop dut (
        .clk(clk),
        .rst(rst),
        .memReq(memReq),
        .readData(readData),
        .inputReady(inputReady),
        .ackOutput(ackOutput),
        .outputValue(outputValue),
        .outputValid(outputValid),
        .halted(halted)
    );

    tbMemory memModel (
        .clk(clk),
        .rst(rst),
        .req(memReq),
        .readData(readData),
        .inputReady(inputReady),
        .ackOutput(ackOutput),
        .writeSeen(writeSeen),
        .writeAddr(writeAddr),
        .writeValue(writeValue)
    );

    function automatic logic [15:0] encodeR(int rs, int rt, int rd, logic [5:0] fn);
        return {4'hF, rs[1:0], rt[1:0], rd[1:0], fn};
    endfunction

    function automatic logic [15:0] encodeI(logic [3:0] op, int rs, int rt, int imm);
        return {op, rs[1:0], rt[1:0], imm[7:0]};
    endfunction

    function automatic logic [15:0] encodeJ(logic [3:0] op, int target);
        return {op, target[11:0]};
    endfunction

    // software model of the ISA that fills the expected queues
    function automatic int executeIsa();
        logic [15:0] r [4];
        logic [15:0] pc;
        logic [15:0] next;
        logic [15:0] w;
        logic [15:0] sext;
        logic [15:0] addr;
        logic [15:0] t;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        int count;
        bit done;
        for (int i = 0; i < 4; i++) begin
            r[i] = '0;
        end
        pc = '0;
        count = 0;
        done = 0;
        while (!done && count < 5000) begin
            w = refMem[pc[7:0]];
            rs = w[11:10];
            rt = w[9:8];
            rd = w[7:6];
            sext = {{8{w[7]}}, w[7:0]};
            addr = r[rs] + sext;
            next = pc + 1;
            count++;
            case (w[15:12])
                4'd0: if (r[rs] != r[rt]) next = next + sext;
                4'd1: if (r[rs] == r[rt]) next = next + sext;
                4'd2: if ($signed(r[rs]) > 0) next = next + sext;
                4'd3: if ($signed(r[rs]) < 0) next = next + sext;
                4'd4: r[rt] = r[rs] + sext;
                4'd5: r[rt] = r[rs] | {8'h00, w[7:0]};
                4'd6: r[rt] = {w[7:0], 8'h00};
                4'd7: r[rt] = refMem[addr[7:0]];
                4'd8: begin
                    refMem[addr[7:0]] = r[rt];
                    expWriteAddr.push_back(addr);
                    expWriteData.push_back(r[rt]);
                end
                4'd9: next = {next[15:12], w[11:0]};
                4'd10: begin
                    r[2] = pc + 1;
                    next = {next[15:12], w[11:0]};
                end
                4'd15: begin
                    case (w[5:0])
                        6'd0: r[rd] = r[rs] + r[rt];
                        6'd1: r[rd] = r[rs] - r[rt];
                        6'd2: r[rd] = r[rs] & r[rt];
                        6'd3: r[rd] = r[rs] | r[rt];
                        6'd4: r[rd] = ~r[rs];
                        6'd5: r[rd] = ~r[rs] + 1;
                        6'd6: r[rd] = {r[rs][14:0], 1'b0};
                        6'd7: r[rd] = {r[rs][15], r[rs][15:1]};
                        6'd25: next = r[rs];
                        6'd26: begin
                            t = r[rs];
                            r[2] = pc + 1;
                            next = t;
                        end
                        6'd28: expOutputs.push_back(r[rs]);
                        6'd29: done = 1;
                        default: ;
                    endcase
                end
                default: ;
            endcase
            pc = next;
        end
        return count;
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic checkValue(input logic [15:0] actual, input logic [15:0] expected,
                              input string what);
        if (actual !== expected) begin
            failRun($sformatf("FAILED %0t: %s is %h, expected %h", $time, what, actual,
                              expected));
        end
    endtask

    task automatic buildProgram();
        int p [progLen];
        p = '{
            encodeI(isaPkg::LHI, 0, 0, 8'h7F), encodeI(isaPkg::ORI, 0, 0, 8'hFF),
            encodeI(isaPkg::ADI, 3, 1, 1), encodeR(0, 1, 2, isaPkg::ADD),
            encodeR(2, 0, 0, isaPkg::WWD), encodeR(1, 0, 3, isaPkg::SUB),
            encodeR(3, 0, 0, isaPkg::WWD), encodeR(0, 2, 3, isaPkg::ORR),
            encodeR(3, 0, 0, isaPkg::WWD), encodeR(1, 0, 3, isaPkg::NOT),
            encodeR(3, 0, 0, isaPkg::WWD), encodeR(0, 0, 3, isaPkg::TCP),
            encodeR(3, 0, 0, isaPkg::WWD), encodeR(0, 0, 3, isaPkg::SHL),
            encodeR(3, 0, 0, isaPkg::WWD), encodeR(2, 0, 3, isaPkg::SHR),
            encodeR(3, 0, 0, isaPkg::WWD), encodeI(isaPkg::ADI, 3, 1, 8'hFD),
            encodeR(1, 0, 0, isaPkg::WWD), encodeI(isaPkg::LHI, 0, 3, 0),
            encodeI(isaPkg::ORI, 3, 3, 8'hC0), encodeI(isaPkg::SWD, 3, 1, 2),
            encodeI(isaPkg::SWD, 3, 0, 8'hFF), encodeI(isaPkg::LWD, 3, 2, 2),
            encodeI(isaPkg::LWD, 3, 1, 5), encodeR(2, 0, 0, isaPkg::WWD),
            encodeR(1, 0, 0, isaPkg::WWD), encodeI(isaPkg::LHI, 0, 1, 0),
            // countdown loop where BGZ jumps back while r1 is positive
            encodeI(isaPkg::ADI, 1, 1, 3), encodeR(1, 0, 0, isaPkg::WWD),
            encodeI(isaPkg::ADI, 1, 1, 8'hFF), encodeI(isaPkg::BGZ, 1, 0, 8'hFD),
            encodeI(isaPkg::BNE, 1, 1, 5), encodeI(isaPkg::BEQ, 1, 1, 1),
            encodeR(0, 0, 0, isaPkg::WWD), encodeI(isaPkg::BLZ, 1, 0, 1),
            encodeI(isaPkg::ADI, 1, 1, 8'hFF), encodeI(isaPkg::BLZ, 1, 0, 1),
            encodeR(0, 0, 0, isaPkg::WWD), encodeI(isaPkg::BNE, 1, 0, 1),
            encodeR(0, 0, 0, isaPkg::WWD), encodeI(isaPkg::BEQ, 1, 0, 5),
            encodeI(isaPkg::BGZ, 1, 0, 1), encodeR(1, 0, 0, isaPkg::WWD),
            encodeJ(isaPkg::JMP, 47), encodeR(0, 0, 0, isaPkg::WWD),
            encodeR(0, 0, 0, isaPkg::WWD), encodeJ(isaPkg::JAL, 50),
            encodeR(2, 0, 0, isaPkg::WWD), encodeJ(isaPkg::JMP, 54),
            encodeR(2, 0, 0, isaPkg::WWD), encodeR(2, 0, 0, isaPkg::JPR),
            encodeR(0, 0, 0, isaPkg::WWD), encodeR(0, 0, 0, isaPkg::WWD),
            encodeI(isaPkg::LHI, 0, 3, 0), encodeI(isaPkg::ORI, 3, 3, 60),
            encodeR(3, 0, 0, isaPkg::JRL), encodeR(0, 0, 0, isaPkg::WWD),
            encodeR(0, 0, 0, isaPkg::WWD), encodeR(0, 0, 0, isaPkg::WWD),
            encodeR(2, 0, 0, isaPkg::WWD), encodeR(0, 0, 0, isaPkg::HLT)
        };
        // fill pattern from the full 8-bit address
        for (int i = 0; i < 256; i++) begin
            image[i] = {i[7:0], ~i[7:0]};
        end
        for (int i = 0; i < progLen; i++) begin
            image[i] = p[i][15:0];
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        cycles = 0;
        haltCycles = 0;
        buildProgram();
        for (int i = 0; i < 256; i++) begin
            refMem[i] = image[i];
            memModel.words[i] = image[i];
        end
        refCount = executeIsa();
        cycleLimit = refCount * 12 + resetCycles;
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
    end

    // compares outputs and writes in program order
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (!rst) begin
            if (outputValid) begin
                if (expOutputs.size() == 0) begin
                    failRun("core produced an output that the reference does not expect");
                end else begin
                    checkValue(outputValue, expOutputs.pop_front(), "output value");
                end
            end
            if (writeSeen) begin
                if (expWriteAddr.size() == 0) begin
                    failRun("core wrote memory more often than the reference");
                end else begin
                    checkValue(writeAddr, expWriteAddr.pop_front(), "store address");
                    checkValue(writeValue, expWriteData.pop_front(), "store data");
                end
            end
            if (halted) begin
                haltCycles <= haltCycles + 1;
                if (memReq.readM || memReq.writeM || outputValid) begin
                    failRun("core kept accessing memory or output after halt");
                end else if (haltCycles == 8) begin
                    if (expOutputs.size() != 0 || expWriteAddr.size() != 0) begin
                        failRun("core halted before all expected outputs and writes");
                    end else begin
                        $display("All checks passed");
                        $finish;
                    end
                end
            end else if (haltCycles != 0) begin
                failRun("halted dropped low after the core had halted");
            end else if (cycles >= cycleLimit) begin
                failRun("timeout, the core never halted");
            end
        end
    end

endmodule

// File: verilog.f
common/isaPkg.sv
common/cpuPkg.sv
datapath/alu.sv
datapath/registerFile.sv
datapath/datapath.sv
source/controlUnit.sv
source/cpuTop.sv
tb/tbMemory.sv
tb/cpuTb.sv

// File: Bender.yml
package:
  name: cpu16

sources:
  - common/isaPkg.sv
  - common/cpuPkg.sv
  - datapath/alu.sv
  - datapath/registerFile.sv
  - datapath/datapath.sv
  - source/controlUnit.sv
  - source/cpuTop.sv
  - target: test
    files:
      - tb/tbMemory.sv
      - tb/cpuTb.sv
